//--- source/cache_macros.svh
// cache sizes and RAM command spacing; the tag width assumes 32-bit byte addresses
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// 16 lines keeps conflict misses easy to reach
`define CACHE_LINE_IX_W 4

// 8 words of 32 bits per line, moved as four 64-bit beats
`define CACHE_COL_IX_W 3

// byte address width on the PSRAM controller side
`define CACHE_RAM_ADDR_W 21

// loaded at each command, the next command waits for zero
`define CACHE_CMD_INTERVAL 13

`define CACHE_TAG_W (32 - `CACHE_LINE_IX_W - `CACHE_COL_IX_W - 2)

`endif

//--- source/cache_pkg.sv
// cache types; the tag word needs two free bits above the tag for the valid and dirty flags
`include "cache_macros.svh"

package cache_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0] byte_en_t;
  typedef logic [`CACHE_LINE_IX_W-1:0] line_ix_t;
  typedef logic [`CACHE_COL_IX_W-1:0] col_ix_t;
  typedef logic [`CACHE_TAG_W-1:0] tag_t;
  // {dirty, valid, tag} zero-extended to a word
  typedef logic [31:0] tag_word_t;
  typedef logic [`CACHE_RAM_ADDR_W-1:0] ram_addr_t;
  typedef logic [63:0] beat_t;

  typedef enum logic [2:0] {
    idle, read_wait, read_beat, read_tag, read_done, write_beat, write_done
  } burst_state_e;

endpackage

//--- source/line_ram.sv
// one word per cache line; write-first, so a written byte shows on data_out after the same edge
`timescale 1ns/10ps

module line_ram (
  input  logic                clk,
  input  cache_pkg::byte_en_t write_enable,
  input  cache_pkg::line_ix_t address,
  input  cache_pkg::word_t    data_in,
  output cache_pkg::word_t    data_out
);
  import cache_pkg::*;

  localparam int depth = 1 << $bits(line_ix_t);

  word_t mem [depth];

  // each byte lane is written and read on its own
  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (write_enable[b]) begin
        mem[address][b*8 +: 8] <= data_in[b*8 +: 8];
        data_out[b*8 +: 8] <= data_in[b*8 +: 8];
      end else begin
        data_out[b*8 +: 8] <= mem[address][b*8 +: 8];
      end
    end
  end

endmodule

//--- source/address_decode.sv
// combinational only; tag_word must come from the line selected by this same address
`timescale 1ns/10ps

module address_decode (
  input  cache_pkg::addr_t     address,
  input  cache_pkg::tag_word_t tag_word,
  output cache_pkg::line_ix_t  line_ix,
  output cache_pkg::col_ix_t   col_ix,
  output cache_pkg::tag_t      tag,
  output logic                 hit,
  output logic                 dirty,
  output cache_pkg::ram_addr_t fill_addr,
  output cache_pkg::ram_addr_t evict_addr
);
  import cache_pkg::*;

  // |tag|line|col|00|
  localparam int line_lsb = 2 + $bits(col_ix_t);
  localparam int tag_lsb = line_lsb + $bits(line_ix_t);
  localparam int tag_w = $bits(tag_t);

  tag_t stored_tag;
  logic stored_valid;
  logic stored_dirty;

  assign col_ix = address[2 +: $bits(col_ix_t)];
  assign line_ix = address[line_lsb +: $bits(line_ix_t)];
  assign tag = address[tag_lsb +: tag_w];

  assign stored_tag = tag_word[tag_w-1:0];
  assign stored_valid = tag_word[tag_w];
  assign stored_dirty = tag_word[tag_w+1];

  assign hit = stored_valid && stored_tag == tag;
  // an invalid line never needs eviction
  assign dirty = stored_valid && stored_dirty;

  // byte addresses of the line start, upper bits beyond the RAM are dropped
  assign fill_addr = ram_addr_t'({address[31:line_lsb], {line_lsb{1'b0}}});
  assign evict_addr = ram_addr_t'({stored_tag, line_ix, {line_lsb{1'b0}}});

endmodule

//--- source/burst_engine.sv
// one miss at a time; address and write_enable must hold while busy, and the RAM never stalls
`timescale 1ns/10ps
`include "cache_macros.svh"

module burst_engine (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable,
  input  logic                 hit,
  input  logic                 dirty,
  input  cache_pkg::ram_addr_t fill_addr,
  input  cache_pkg::ram_addr_t evict_addr,
  input  cache_pkg::word_t     col_data [1 << `CACHE_COL_IX_W],
  output logic                 busy,
  output logic                 filling,
  output cache_pkg::byte_en_t  fill_we [1 << `CACHE_COL_IX_W],
  output cache_pkg::word_t     fill_data [1 << `CACHE_COL_IX_W],
  output logic                 tag_fill,
  output logic                 br_cmd,
  output logic                 br_cmd_en,
  output cache_pkg::ram_addr_t br_addr,
  output cache_pkg::beat_t     br_wr_data,
  input  cache_pkg::beat_t     br_rd_data,
  input  logic                 br_rd_data_valid
);
  import cache_pkg::*;

  localparam int col_count = 1 << `CACHE_COL_IX_W;
  localparam int cnt_w = $clog2(`CACHE_CMD_INTERVAL + 1);

  burst_state_e state;
  burst_state_e state_d;
  logic [cnt_w-1:0] interval_cnt;
  // beat within the burst, wraps back to zero at the end of each burst
  logic [1:0] beat;
  logic miss_start;
  logic start_evict;
  logic start_fill;
  logic cmd_issue;
  logic take_beat;
  logic send_beat;

  assign busy = (enable && !hit) || interval_cnt != '0;

  assign miss_start = state == idle && enable && !hit && interval_cnt == '0;
  assign start_evict = miss_start && dirty;
  assign start_fill = (miss_start && !dirty) || (state == write_done && interval_cnt == '0);
  assign cmd_issue = start_evict || start_fill;
  assign take_beat = (state == read_wait && br_rd_data_valid) || state == read_beat;
  assign send_beat = start_evict || state == write_beat;

  always_comb begin
    state_d = state;
    case (state)
      idle:       if (start_evict) state_d = write_beat;
                  else if (start_fill) state_d = read_wait;
      write_beat: if (beat == 2'd3) state_d = write_done;
      write_done: if (start_fill) state_d = read_wait;
      read_wait:  if (br_rd_data_valid) state_d = read_beat;
      read_beat:  if (beat == 2'd3) state_d = read_tag;
      read_tag:   state_d = read_done;
      read_done:  state_d = idle;
      default:    state_d = idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
      interval_cnt <= '0;
      beat <= '0;
      br_cmd_en <= 1'b0;
      filling <= 1'b0;
      tag_fill <= 1'b0;
      for (int i = 0; i < col_count; i++) begin
        fill_we[i] <= '0;
      end
    end else begin
      state <= state_d;
      br_cmd_en <= cmd_issue;
      if (cmd_issue) begin
        interval_cnt <= cnt_w'(`CACHE_CMD_INTERVAL);
      end else if (interval_cnt != '0) begin
        interval_cnt <= interval_cnt - 1'b1;
      end
      if (take_beat || send_beat) begin
        beat <= beat + 1'b1;
      end
      // two columns per incoming beat
      for (int i = 0; i < col_count; i++) begin
        fill_we[i] <= (take_beat && (i >> 1) == int'(beat)) ? 4'hf : 4'h0;
      end
      // tag goes in only after the last columns have settled
      tag_fill <= state == read_tag;
      if (start_fill) begin
        filling <= 1'b1;
      end else if (state == read_done) begin
        filling <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_issue) begin
      br_cmd <= start_evict;
      br_addr <= start_evict ? evict_addr : fill_addr;
    end
    // first write beat goes out together with the command
    if (send_beat) begin
      br_wr_data <= {col_data[{beat, 1'b1}], col_data[{beat, 1'b0}]};
    end
    if (take_beat) begin
      fill_data[{beat, 1'b0}] <= br_rd_data[31:0];
      fill_data[{beat, 1'b1}] <= br_rd_data[63:32];
    end
  end

endmodule

//--- source/line_store.sv
// tag and column storage; reads are registered, so data follows the line index by one cycle
`timescale 1ns/10ps
`include "cache_macros.svh"

module line_store (
  input  logic                 clk,
  input  logic                 filling,
  input  cache_pkg::byte_en_t  fill_we [1 << `CACHE_COL_IX_W],
  input  cache_pkg::word_t     fill_data [1 << `CACHE_COL_IX_W],
  input  logic                 tag_fill,
  input  cache_pkg::tag_t      tag,
  input  logic                 hit,
  input  logic                 enable,
  input  cache_pkg::byte_en_t  write_enable,
  input  cache_pkg::word_t     data_in,
  input  cache_pkg::line_ix_t  line_ix,
  input  cache_pkg::col_ix_t   col_ix,
  output cache_pkg::tag_word_t tag_word,
  output cache_pkg::word_t     col_data [1 << `CACHE_COL_IX_W],
  output cache_pkg::word_t     data_out,
  output logic                 data_out_ready
);
  import cache_pkg::*;

  localparam int col_count = 1 << `CACHE_COL_IX_W;

  logic hit_write;
  byte_en_t tag_we;
  tag_word_t tag_din;
  byte_en_t col_we [col_count];
  word_t col_din [col_count];

  assign hit_write = enable && hit && write_enable != '0 && !filling;

  // a fill leaves the line clean, a hit write marks it dirty
  assign tag_we = (tag_fill || hit_write) ? 4'hf : 4'h0;
  assign tag_din = tag_word_t'({hit_write, 1'b1, tag});

  always_comb begin
    for (int i = 0; i < col_count; i++) begin
      if (filling) begin
        col_we[i] = fill_we[i];
        col_din[i] = fill_data[i];
      end else begin
        col_we[i] = (hit_write && int'(col_ix) == i) ? write_enable : 4'h0;
        col_din[i] = data_in;
      end
    end
  end

  line_ram tag_ram (
    .clk          (clk),
    .write_enable (tag_we),
    .address      (line_ix),
    .data_in      (tag_din),
    .data_out     (tag_word)
  );

  for (genvar i = 0; i < col_count; i++) begin : g_col
    line_ram col_ram (
      .clk          (clk),
      .write_enable (col_we[i]),
      .address      (line_ix),
      .data_in      (col_din[i]),
      .data_out     (col_data[i])
    );
  end

  assign data_out = col_data[col_ix];
  assign data_out_ready = enable && hit && write_enable == '0;

endmodule

//--- source/burst_cache.sv
// direct-mapped write-back cache; byte-addressed RAM only, whole-line bursts, no flush
`timescale 1ns/10ps
`include "cache_macros.svh"

module burst_cache (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 enable,
  input  cache_pkg::addr_t     address,
  input  cache_pkg::word_t     data_in,
  input  cache_pkg::byte_en_t  write_enable,
  output cache_pkg::word_t     data_out,
  output logic                 data_out_ready,
  output logic                 busy,
  output logic                 br_cmd,
  output logic                 br_cmd_en,
  output cache_pkg::ram_addr_t br_addr,
  output cache_pkg::beat_t     br_wr_data,
  output logic [7:0]           br_data_mask,
  input  cache_pkg::beat_t     br_rd_data,
  input  logic                 br_rd_data_valid
);
  import cache_pkg::*;

  localparam int col_count = 1 << `CACHE_COL_IX_W;

  line_ix_t line_ix;
  col_ix_t col_ix;
  tag_t tag;
  logic hit;
  logic dirty;
  ram_addr_t fill_addr;
  ram_addr_t evict_addr;
  tag_word_t tag_word;
  word_t col_data [col_count];
  logic filling;
  byte_en_t fill_we [col_count];
  word_t fill_data [col_count];
  logic tag_fill;

  // whole lines are always written
  assign br_data_mask = 8'h00;

  address_decode address_decode_i (
    .address    (address),
    .tag_word   (tag_word),
    .line_ix    (line_ix),
    .col_ix     (col_ix),
    .tag        (tag),
    .hit        (hit),
    .dirty      (dirty),
    .fill_addr  (fill_addr),
    .evict_addr (evict_addr)
  );

  burst_engine burst_engine_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .enable           (enable),
    .hit              (hit),
    .dirty            (dirty),
    .fill_addr        (fill_addr),
    .evict_addr       (evict_addr),
    .col_data         (col_data),
    .busy             (busy),
    .filling          (filling),
    .fill_we          (fill_we),
    .fill_data        (fill_data),
    .tag_fill         (tag_fill),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  line_store line_store_i (
    .clk            (clk),
    .filling        (filling),
    .fill_we        (fill_we),
    .fill_data      (fill_data),
    .tag_fill       (tag_fill),
    .tag            (tag),
    .hit            (hit),
    .enable         (enable),
    .write_enable   (write_enable),
    .data_in        (data_in),
    .line_ix        (line_ix),
    .col_ix         (col_ix),
    .tag_word       (tag_word),
    .col_data       (col_data),
    .data_out       (data_out),
    .data_out_ready (data_out_ready)
  );

endmodule

//--- tb/burst_ram_model.sv
// behavioral PSRAM for whole-line bursts only; first read beat is sampled four cycles after the command
`timescale 1ns/10ps

module burst_ram_model (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 br_cmd,
  input  logic                 br_cmd_en,
  input  cache_pkg::ram_addr_t br_addr,
  input  cache_pkg::beat_t     br_wr_data,
  output cache_pkg::beat_t     br_rd_data,
  output logic                 br_rd_data_valid
);
  import cache_pkg::*;

  // sparse store, only written words are kept
  word_t mem [int unsigned];
  int unsigned rd_word;
  int unsigned wr_word;
  int rd_delay;
  int rd_left;
  int wr_left;

  function automatic word_t read_word(input int unsigned w);
    word_t v;
    if (mem.exists(w)) begin
      v = mem[w];
    end else begin
      v = w ^ 32'ha5a5_0000;
    end
    return v;
  endfunction

  function automatic void store_beat(input int unsigned w, input beat_t b);
    mem[w] = b[31:0];
    mem[w + 1] = b[63:32];
  endfunction

  // everything moves on the falling edge, half a cycle away from the DUT
  always @(negedge clk or negedge rst_n) begin
    if (!rst_n) begin
      br_rd_data <= '0;
      br_rd_data_valid <= 1'b0;
      rd_delay = 0;
      rd_left = 0;
      wr_left = 0;
    end else begin
      br_rd_data_valid <= 1'b0;
      if (rd_left != 0) begin
        br_rd_data <= {read_word(rd_word + 1), read_word(rd_word)};
        rd_word = rd_word + 2;
        rd_left = rd_left - 1;
      end else if (rd_delay != 0) begin
        rd_delay = rd_delay - 1;
        if (rd_delay == 0) begin
          // valid marks only the first of the four beats
          br_rd_data <= {read_word(rd_word + 1), read_word(rd_word)};
          br_rd_data_valid <= 1'b1;
          rd_word = rd_word + 2;
          rd_left = 3;
        end
      end
      if (br_cmd_en && !br_cmd) begin
        rd_word = int'(br_addr >> 2);
        rd_delay = 3;
      end
      // first write beat arrives with the command
      if (br_cmd_en && br_cmd) begin
        wr_word = int'(br_addr >> 2);
        store_beat(wr_word, br_wr_data);
        wr_word = wr_word + 2;
        wr_left = 3;
      end else if (wr_left != 0) begin
        store_beat(wr_word, br_wr_data);
        wr_word = wr_word + 2;
        wr_left = wr_left - 1;
      end
    end
  end

endmodule

//--- tb/burst_cache_sva.sv
// bound into burst_cache; the spacing check trusts the interval from the macros header
`timescale 1ns/10ps
`include "cache_macros.svh"

module burst_cache_sva (
  input logic clk,
  input logic rst_n,
  input logic br_cmd_en,
  input logic data_out_ready,
  input logic filling
);

  localparam int gap_w = $clog2(`CACHE_CMD_INTERVAL + 1);

  // cycles left before another command is allowed
  logic [gap_w-1:0] gap;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      gap <= '0;
    end else if (br_cmd_en) begin
      gap <= gap_w'(`CACHE_CMD_INTERVAL);
    end else if (gap != '0) begin
      gap <= gap - 1'b1;
    end
  end

  a_cmd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |=> !br_cmd_en)
    else $error("br_cmd_en stayed high for more than one cycle");

  a_cmd_gap: assert property (@(posedge clk) disable iff (!rst_n)
    br_cmd_en |-> gap == '0)
    else $error("RAM command issued inside the command interval");

  // the line must not hit before its tag is written at the end of the fill
  a_ready_not_filling: assert property (@(posedge clk) disable iff (!rst_n)
    filling |-> !data_out_ready)
    else $error("data_out_ready high while a line fill is in progress");

endmodule

bind burst_cache burst_cache_sva burst_cache_sva_i (
  .clk            (clk),
  .rst_n          (rst_n),
  .br_cmd_en      (br_cmd_en),
  .data_out_ready (data_out_ready),
  .filling        (filling)
);

//--- tb/burst_cache_tb.sv
// reads tb/cache_trace.txt from the run directory; assumes the tag RAM powers up cleared
`timescale 1ns/10ps

module burst_cache_tb;
  import cache_pkg::*;

  localparam int line_lsb = 2 + $bits(col_ix_t);
  localparam int tag_lsb = line_lsb + $bits(line_ix_t);
  localparam int line_count = 1 << $bits(line_ix_t);
  localparam int line_bytes = 4 << $bits(col_ix_t);

  logic clk = 1'b0;
  logic rst_n;
  logic enable;
  addr_t address;
  word_t data_in;
  byte_en_t write_enable;
  word_t data_out;
  logic data_out_ready;
  logic busy;
  logic br_cmd;
  logic br_cmd_en;
  ram_addr_t br_addr;
  beat_t br_wr_data;
  logic [7:0] br_data_mask;
  beat_t br_rd_data;
  logic br_rd_data_valid;

  // trace columns
  logic [7:0] op_q [$];
  addr_t addr_q [$];
  word_t data_q [$];
  byte_en_t mask_q [$];
  word_t exp_q [$];
  // commands of the current op with the write flag above the address
  logic [$bits(ram_addr_t):0] cmd_q [$];

  // expected line state under the direct-mapped rules
  logic ref_valid [line_count];
  logic ref_dirty [line_count];
  tag_t ref_tag [line_count];
  // RAM address each line was last filled from
  ram_addr_t ref_base [line_count];

  int errors = 0;
  int read_cmds = 0;
  int write_cmds = 0;
  int exp_writes = 0;
  int op_limit = 0;

  always #50 clk = ~clk;

  burst_cache burst_cache_i (.*);

  burst_ram_model ram_model_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid)
  );

  always @(posedge clk) begin
    if (rst_n && br_cmd_en) begin
      cmd_q.push_back({br_cmd, br_addr});
      if (br_cmd) write_cmds++;
      else read_cmds++;
      if (br_data_mask != 8'h00) begin
        report_error($sformatf("data mask %h on a RAM command, expected 00", br_data_mask));
      end
    end
  end

  task automatic report_error(input string msg);
    errors++;
    $display("ERR %0t ns: %s", $time, msg);
  endtask

  task automatic load_trace(output bit ok);
    int fd;
    int n;
    string text;
    logic [7:0] op;
    addr_t a;
    word_t d;
    byte_en_t m;
    word_t e;
    ok = 1'b0;
    fd = $fopen("tb/cache_trace.txt", "r");
    if (fd != 0) begin
      while ($fgets(text, fd) != 0) begin
        if (text.len() > 1 && text.getc(0) != "#") begin
          n = $sscanf(text, "%c %h %h %h %h", op, a, d, m, e);
          if (n == 5 && (op == "R" || op == "W")) begin
            op_q.push_back(op);
            addr_q.push_back(a);
            data_q.push_back(d);
            mask_q.push_back(m);
            exp_q.push_back(e);
          end else begin
            errors++;
            $display("trace line could not be read: %s", text);
          end
        end
      end
      $fclose(fd);
      ok = 1'b1;
    end
  endtask

  task automatic run_op(input int i);
    int waited;
    int exp_cmds;
    logic miss;
    logic evict;
    line_ix_t ix;
    tag_t tg;
    ram_addr_t fill_a;
    ram_addr_t evict_a;
    ix = addr_q[i][line_lsb +: $bits(line_ix_t)];
    tg = addr_q[i][tag_lsb +: $bits(tag_t)];
    miss = !(ref_valid[ix] && ref_tag[ix] == tg);
    evict = miss && ref_valid[ix] && ref_dirty[ix];
    exp_cmds = evict ? 2 : (miss ? 1 : 0);
    fill_a = ram_addr_t'(addr_q[i]) & ~ram_addr_t'(line_bytes - 1);
    evict_a = ref_base[ix];
    // address settles one cycle before enable
    @(negedge clk);
    address = addr_q[i];
    data_in = data_q[i];
    write_enable = '0;
    cmd_q.delete();
    @(negedge clk);
    enable = 1'b1;
    waited = 0;
    @(negedge clk);
    while (busy) begin
      waited++;
      @(negedge clk);
    end
    if (!miss && waited != 0) begin
      report_error($sformatf("op %0d: busy high for %0d cycles on a hit", i, waited));
    end
    if (miss && waited == 0) begin
      report_error($sformatf("op %0d: busy never rose on a miss", i));
    end
    if (op_q[i] == "W") begin
      write_enable = mask_q[i];
      @(negedge clk);
    end else if (!data_out_ready) begin
      report_error($sformatf("op %0d: data_out_ready low on read of %h", i, addr_q[i]));
    end else if (data_out !== exp_q[i]) begin
      report_error($sformatf("op %0d: read %h gave %h, expected %h",
                             i, addr_q[i], data_out, exp_q[i]));
    end
    enable = 1'b0;
    write_enable = '0;
    if (cmd_q.size() != exp_cmds) begin
      report_error($sformatf("op %0d: %0d RAM commands, expected %0d", i, cmd_q.size(), exp_cmds));
    end else begin
      if (evict && cmd_q[0] != {1'b1, evict_a}) begin
        report_error($sformatf("op %0d: eviction command %h, expected write at %h",
                               i, cmd_q[0], evict_a));
      end
      if (miss && cmd_q[exp_cmds-1] != {1'b0, fill_a}) begin
        report_error($sformatf("op %0d: fill command %h, expected read at %h",
                               i, cmd_q[exp_cmds-1], fill_a));
      end
    end
    if (evict) exp_writes++;
    if (miss) begin
      ref_valid[ix] = 1'b1;
      ref_dirty[ix] = 1'b0;
      ref_tag[ix] = tg;
      ref_base[ix] = fill_a;
    end
    if (op_q[i] == "W") ref_dirty[ix] = 1'b1;
  endtask

  initial begin
    bit ok;
    rst_n = 1'b0;
    enable = 1'b0;
    address = '0;
    data_in = '0;
    write_enable = '0;
    for (int l = 0; l < line_count; l++) begin
      ref_valid[l] = 1'b0;
      ref_dirty[l] = 1'b0;
      ref_tag[l] = '0;
      ref_base[l] = '0;
    end
    load_trace(ok);
    if (!ok || op_q.size() == 0) begin
      $display("trace file tb/cache_trace.txt is missing or holds no operations");
      $display("CHECKS FAILED");
      $finish;
    end else begin
      op_limit = op_q.size() * 60 + 8;
      repeat (8) @(negedge clk);
      if (br_cmd_en || busy || data_out_ready) begin
        report_error("outputs not low during reset");
      end
      rst_n = 1'b1;
      for (int i = 0; i < op_q.size(); i++) begin
        run_op(i);
      end
      if (write_cmds != exp_writes) begin
        report_error($sformatf("%0d write commands, expected %0d", write_cmds, exp_writes));
      end
      $display("errors %0d, ops %0d, read commands %0d, write commands %0d",
               errors, op_q.size(), read_cmds, write_cmds);
      if (errors == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

  // run length limit from the op count
  initial begin
    wait (op_limit != 0);
    repeat (op_limit) @(posedge clk);
    $display("timeout after %0d clock cycles, the cache never finished the trace", op_limit);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- src.f
+incdir+source
source/cache_pkg.sv
source/line_ram.sv
source/address_decode.sv
source/burst_engine.sv
source/line_store.sv
source/burst_cache.sv
tb/burst_ram_model.sv
tb/burst_cache_sva.sv
tb/burst_cache_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -j 0 --top-module burst_cache_tb -f src.f -o burst_cache_sim \
  && ./obj_dir/burst_cache_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- tb/cache_trace.txt
# op address data mask expected (hex); W ignores expected, R ignores data and mask
# unwritten RAM words read as their word address xor a5a50000
R 00000104 00000000 0 a5a50041
R 00000118 00000000 0 a5a50046
W 00000108 11223344 5 00000000
R 00000108 00000000 0 a5220044
W 0000010c deadbeef f 00000000
R 0000010c 00000000 0 deadbeef
R 00000304 00000000 0 a5a500c1
R 00000108 00000000 0 a5220044
R 0000010c 00000000 0 deadbeef
R 00000304 00000000 0 a5a500c1
R 00000020 00000000 0 a5a50008
W 00000034 cafef00d 3 00000000
R 00000034 00000000 0 a5a5f00d
R 00001020 00000000 0 a5a50408
R 00000034 00000000 0 a5a5f00d
R 000001e0 00000000 0 a5a50078
W 000003e4 0badf00d 8 00000000
R 000003e4 00000000 0 0ba500f9
R 000001e0 00000000 0 a5a50078
R 000003e4 00000000 0 0ba500f9
